/* src/sub_map_pkg.sv */
package sub_map_pkg;

    // Sub CPU address word
    // Flat view drives the ROM, I/O view splits C000-FFFF into devices
    typedef union packed {
        logic [15:0] flat;
        struct packed {
            // 11 selects the I/O space at C000 and up
            logic [1:0] bank;
            // Device select: C, D or E page group
            logic [1:0] sel;
            // Sub page inside a 4 kB group
            logic [1:0] page;
            // Byte offset inside a 1 kB page
            logic [9:0] offset;
        } io;
    } sub_addr_u;

    // Bank value of the I/O space
    localparam logic [1:0] IO_BANK = 2'b11;

    // Device selects inside the I/O bank
    // C000 shared RAM
    localparam logic [1:0] SEL_SHARED = 2'b00;
    // D000 NMI acknowledge
    localparam logic [1:0] SEL_NMI_ACK = 2'b01;
    // E000 interrupt to the main CPU
    localparam logic [1:0] SEL_IRQ_MAIN = 2'b10;

    // Only page 0 of the C group holds RAM
    localparam logic [1:0] SHARED_PAGE = 2'b00;

    // ROM occupies everything below this address
    localparam logic [15:0] ROM_TOP = 16'hc000;

    // Value read back from unmapped addresses
    localparam logic [7:0] OPEN_BUS = 8'hff;

endpackage

/* src/sub_bus_pkg.sv */
package sub_bus_pkg;

    // Data byte on both CPU buses
    typedef logic [7:0] byte_t;

    // Kind of the sub CPU bus cycle in progress
    // Idle also covers cycles ignored while the main side owns the bus
    typedef enum logic [1:0] {
        CYC_IDLE    = 2'b00,
        CYC_REFRESH = 2'b01,
        CYC_READ    = 2'b10,
        CYC_WRITE   = 2'b11
    } cycle_e;

    // Strobe levels of the sub bus, all active low
    localparam logic STROBE_ON  = 1'b0;
    localparam logic STROBE_OFF = 1'b1;

endpackage

/* src/sub_ctrl.sv */
`timescale 1ns/1ps

module sub_ctrl #(
    parameter int RST_TICKS = 15
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    input  logic mcu_rstb,
    input  logic main_nmi_set,
    input  logic nmi_ack_wr,
    input  logic irq_wr,
    output logic sub_rst_n,
    output logic sub_nmi_n,
    output logic main_irq
);

    // One spare bit so that RST_TICKS itself fits
    localparam int CW = $clog2(RST_TICKS + 2);

    logic [CW-1:0] rst_cnt;
    logic          nmi_set_q;
    logic          nmi_rise;
    logic          nmi_latch;

    // Reset stretcher
    // Counts cen ticks, restarted by either reset source
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_cnt   <= CW'(RST_TICKS);
            sub_rst_n <= 1'b0;
        end else if (!mcu_rstb) begin
            // Main CPU holds the sub in reset
            rst_cnt   <= CW'(RST_TICKS);
            sub_rst_n <= 1'b0;
        end else if (cen) begin
            if (rst_cnt != '0) begin
                rst_cnt <= rst_cnt - 1'b1;
            end
            // Release on the tick that empties the counter
            sub_rst_n <= (rst_cnt <= CW'(1));
        end
    end

    // Request edge from the main side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nmi_set_q <= 1'b0;
        end else begin
            nmi_set_q <= main_nmi_set;
        end
    end

    assign nmi_rise = main_nmi_set & ~nmi_set_q;

    // NMI latch
    // Held clear while the sub CPU sits in reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nmi_latch <= 1'b0;
        end else if (!sub_rst_n) begin
            nmi_latch <= 1'b0;
        end else if (nmi_rise) begin
            // New request beats a simultaneous acknowledge
            nmi_latch <= 1'b1;
        end else if (nmi_ack_wr) begin
            nmi_latch <= 1'b0;
        end
    end

    assign sub_nmi_n = ~nmi_latch;

    // Single cycle interrupt pulse to the main CPU
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_irq <= 1'b0;
        end else begin
            main_irq <= irq_wr;
        end
    end

endmodule

/* src/sub_addr_decode.sv */
`timescale 1ns/1ps

module sub_addr_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sub_map_pkg::sub_addr_u sub_addr,
    input  logic                  sub_mreq_n,
    input  logic                  sub_rfsh_n,
    input  logic                  sub_wr_n,
    input  logic                  bus_granted,
    input  sub_bus_pkg::byte_t    rom_data,
    input  logic                  rom_ok,
    input  sub_bus_pkg::byte_t    ram_q,
    output logic                  rom_cs,
    output logic                  sub_wait_n,
    output logic                  shared_cs,
    output logic                  nmi_ack_wr,
    output logic                  irq_wr,
    output logic                  wr_fall,
    output sub_bus_pkg::byte_t    sub_din
);

    sub_bus_pkg::cycle_e cycle;
    logic                in_rom;
    logic                in_io;
    logic                in_shared;
    logic                in_nmi_ack;
    logic                in_irq_main;
    logic                access;
    logic                wr_n_q;

    // Cycle classification
    // Nothing is decoded while the main side owns the bus
    always_comb begin
        if (sub_mreq_n == sub_bus_pkg::STROBE_OFF || bus_granted) begin
            cycle = sub_bus_pkg::CYC_IDLE;
        end else if (sub_rfsh_n == sub_bus_pkg::STROBE_ON) begin
            cycle = sub_bus_pkg::CYC_REFRESH;
        end else if (sub_wr_n == sub_bus_pkg::STROBE_ON) begin
            cycle = sub_bus_pkg::CYC_WRITE;
        end else begin
            cycle = sub_bus_pkg::CYC_READ;
        end
    end

    // Real memory access, refresh excluded
    assign access = (cycle == sub_bus_pkg::CYC_READ) || (cycle == sub_bus_pkg::CYC_WRITE);

    // Region decode
    // ROM through the flat view, devices through the I/O fields
    assign in_rom      = sub_addr.flat < sub_map_pkg::ROM_TOP;
    assign in_io       = sub_addr.io.bank == sub_map_pkg::IO_BANK;
    assign in_shared   = in_io && sub_addr.io.sel == sub_map_pkg::SEL_SHARED
                         && sub_addr.io.page == sub_map_pkg::SHARED_PAGE;
    assign in_nmi_ack  = in_io && sub_addr.io.sel == sub_map_pkg::SEL_NMI_ACK;
    assign in_irq_main = in_io && sub_addr.io.sel == sub_map_pkg::SEL_IRQ_MAIN;

    // ROM is only fetched, never written
    assign rom_cs    = (cycle == sub_bus_pkg::CYC_READ) && in_rom;
    assign shared_cs = access && in_shared;

    // Wait state until the ROM data is valid
    assign sub_wait_n = ~(rom_cs & ~rom_ok);

    // Previous write strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_n_q <= sub_bus_pkg::STROBE_OFF;
        end else begin
            wr_n_q <= sub_wr_n;
        end
    end

    // First low cycle of sub_wr_n only
    assign wr_fall = wr_n_q & ~sub_wr_n;

    // Device strobes, one per write
    assign nmi_ack_wr = wr_fall && (cycle == sub_bus_pkg::CYC_WRITE) && in_nmi_ack;
    assign irq_wr     = wr_fall && (cycle == sub_bus_pkg::CYC_WRITE) && in_irq_main;

    // Read data
    // RAM output already lags the address by one clock
    always_comb begin
        if (rom_cs) begin
            sub_din = rom_data;
        end else if (shared_cs) begin
            sub_din = ram_q;
        end else begin
            sub_din = sub_map_pkg::OPEN_BUS;
        end
    end

endmodule

/* src/shared_ram.sv */
`timescale 1ns/1ps

module shared_ram #(
    parameter int SHARED_AW = 10
) (
    input  logic                 clk,
    input  logic [SHARED_AW-1:0] a_addr,
    input  sub_bus_pkg::byte_t   a_din,
    input  logic                 a_we,
    input  logic [SHARED_AW-2:0] b_addr,
    input  sub_bus_pkg::byte_t   b_din,
    input  logic                 b_we,
    output sub_bus_pkg::byte_t   a_q,
    output sub_bus_pkg::byte_t   b_q
);

    localparam int DEPTH = 2 ** SHARED_AW;

    sub_bus_pkg::byte_t   mem [DEPTH];
    logic [SHARED_AW-1:0] b_addr_x;

    // Main side reaches the lower half only
    assign b_addr_x = {1'b0, b_addr};

    // Both ports in one process
    // Port A is the sub CPU, port B the main CPU
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
        // Main write wins a same address collision
        if (b_we) begin
            mem[b_addr_x] <= b_din;
        end
        // Registered reads, old data on a write
        a_q <= mem[a_addr];
        b_q <= mem[b_addr_x];
    end

endmodule

/* src/main_bus_arbiter.sv */
`timescale 1ns/1ps

module main_bus_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic main_halt_req,
    input  logic sub_mreq_n,
    input  logic main_cs,
    input  logic main_wr_n,
    output logic main_halt_ack,
    output logic sub_busak_n,
    output logic bus_granted,
    output logic main_we
);

    // Grant state
    localparam logic ST_IDLE  = 1'b0;
    localparam logic ST_GRANT = 1'b1;

    logic state;
    logic state_nxt;

    // Four phase handshake
    // Grant waits for a gap between sub bus cycles
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (main_halt_req && sub_mreq_n) begin
                    state_nxt = ST_GRANT;
                end
            end
            ST_GRANT: begin
                // Held for as long as the request stays up
                if (!main_halt_req) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign bus_granted   = state == ST_GRANT;
    assign main_halt_ack = bus_granted;
    assign sub_busak_n   = ~bus_granted;

    // Main writes are dropped without the grant
    assign main_we = bus_granted & main_cs & ~main_wr_n;

endmodule

/* src/sub_bridge_top.sv */
`timescale 1ns/1ps

module sub_bridge_top #(
    parameter int SHARED_AW = 10,
    parameter int RST_TICKS = 15
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 mcu_rstb,
    // Sub CPU bus
    input  logic [15:0]          sub_addr,
    input  logic                 sub_mreq_n,
    input  logic                 sub_rfsh_n,
    input  logic                 sub_wr_n,
    input  sub_bus_pkg::byte_t   sub_dout,
    output sub_bus_pkg::byte_t   sub_din,
    output logic                 sub_wait_n,
    output logic                 sub_nmi_n,
    output logic                 sub_rst_n,
    output logic                 sub_busak_n,
    // Program ROM
    output logic [15:0]          rom_addr,
    output logic                 rom_cs,
    input  sub_bus_pkg::byte_t   rom_data,
    input  logic                 rom_ok,
    // Main CPU side
    input  logic [SHARED_AW-2:0] main_addr,
    input  sub_bus_pkg::byte_t   main_dout,
    input  logic                 main_wr_n,
    input  logic                 main_cs,
    input  logic                 main_halt_req,
    input  logic                 main_nmi_set,
    output logic                 main_halt_ack,
    output sub_bus_pkg::byte_t   shared_dout,
    output logic                 main_irq
);

    logic               shared_cs;
    logic               nmi_ack_wr;
    logic               irq_wr;
    logic               wr_fall;
    logic               bus_granted;
    logic               main_we;
    sub_bus_pkg::byte_t ram_q;

    // ROM sees the sub address unchanged
    assign rom_addr = sub_addr;

    // Reset, NMI and main interrupt
    sub_ctrl #(
        .RST_TICKS (RST_TICKS)
    ) sub_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .mcu_rstb     (mcu_rstb),
        .main_nmi_set (main_nmi_set),
        .nmi_ack_wr   (nmi_ack_wr),
        .irq_wr       (irq_wr),
        .sub_rst_n    (sub_rst_n),
        .sub_nmi_n    (sub_nmi_n),
        .main_irq     (main_irq)
    );

    // Sub memory map and read path
    sub_addr_decode sub_addr_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sub_addr    (sub_addr),
        .sub_mreq_n  (sub_mreq_n),
        .sub_rfsh_n  (sub_rfsh_n),
        .sub_wr_n    (sub_wr_n),
        .bus_granted (bus_granted),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .ram_q       (ram_q),
        .rom_cs      (rom_cs),
        .sub_wait_n  (sub_wait_n),
        .shared_cs   (shared_cs),
        .nmi_ack_wr  (nmi_ack_wr),
        .irq_wr      (irq_wr),
        .wr_fall     (wr_fall),
        .sub_din     (sub_din)
    );

    // Shared RAM, one write per sub write strobe
    shared_ram #(
        .SHARED_AW (SHARED_AW)
    ) shared_ram_inst (
        .clk    (clk),
        .a_addr (sub_addr[SHARED_AW-1:0]),
        .a_din  (sub_dout),
        .a_we   (wr_fall & shared_cs),
        .b_addr (main_addr),
        .b_din  (main_dout),
        .b_we   (main_we),
        .a_q    (ram_q),
        .b_q    (shared_dout)
    );

    // Halt handshake with the main CPU
    main_bus_arbiter main_bus_arbiter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .main_halt_req (main_halt_req),
        .sub_mreq_n    (sub_mreq_n),
        .main_cs       (main_cs),
        .main_wr_n     (main_wr_n),
        .main_halt_ack (main_halt_ack),
        .sub_busak_n   (sub_busak_n),
        .bus_granted   (bus_granted),
        .main_we       (main_we)
    );

endmodule

/* verification/tb_sub_bridge.sv */
`timescale 1ns/1ps

module tb_sub_bridge;

    localparam int SHARED_AW = 10;
    localparam int RST_TICKS = 15;
    // Drive point after the rising edge, and settle time for combinational paths
    localparam int DRV = 1;
    localparam int SETTLE = 10;
    localparam int TIMEOUT = 200;
    // Bytes covered by the shared RAM test, C000 to C1FF
    localparam int SPAN = 512;

    typedef logic [SHARED_AW-2:0] main_addr_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cen = 1'b0;
    logic                 mcu_rstb;
    logic [15:0]          sub_addr;
    logic                 sub_mreq_n;
    logic                 sub_rfsh_n;
    logic                 sub_wr_n;
    sub_bus_pkg::byte_t   sub_dout;
    sub_bus_pkg::byte_t   sub_din;
    logic                 sub_wait_n;
    logic                 sub_nmi_n;
    logic                 sub_rst_n;
    logic                 sub_busak_n;
    logic [15:0]          rom_addr;
    logic                 rom_cs;
    sub_bus_pkg::byte_t   rom_data;
    logic                 rom_ok;
    main_addr_t           main_addr;
    sub_bus_pkg::byte_t   main_dout;
    logic                 main_wr_n;
    logic                 main_cs;
    logic                 main_halt_req;
    logic                 main_nmi_set;
    logic                 main_halt_ack;
    sub_bus_pkg::byte_t   shared_dout;
    logic                 main_irq;

    logic [1:0]           cen_phase = 2'd0;
    int                   cen_seen = 0;
    // Expected shared RAM contents, indexed by offset from C000
    sub_bus_pkg::byte_t   model [$];

    sub_bridge_top #(
        .SHARED_AW (SHARED_AW),
        .RST_TICKS (RST_TICKS)
    ) sub_bridge_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cen           (cen),
        .mcu_rstb      (mcu_rstb),
        .sub_addr      (sub_addr),
        .sub_mreq_n    (sub_mreq_n),
        .sub_rfsh_n    (sub_rfsh_n),
        .sub_wr_n      (sub_wr_n),
        .sub_dout      (sub_dout),
        .sub_din       (sub_din),
        .sub_wait_n    (sub_wait_n),
        .sub_nmi_n     (sub_nmi_n),
        .sub_rst_n     (sub_rst_n),
        .sub_busak_n   (sub_busak_n),
        .rom_addr      (rom_addr),
        .rom_cs        (rom_cs),
        .rom_data      (rom_data),
        .rom_ok        (rom_ok),
        .main_addr     (main_addr),
        .main_dout     (main_dout),
        .main_wr_n     (main_wr_n),
        .main_cs       (main_cs),
        .main_halt_req (main_halt_req),
        .main_nmi_set  (main_nmi_set),
        .main_halt_ack (main_halt_ack),
        .shared_dout   (shared_dout),
        .main_irq      (main_irq)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Clock enable, one cycle in four
    always @(posedge clk) begin
        #DRV;
        cen_phase = cen_phase + 2'd1;
        cen = (cen_phase == 2'd0);
    end

    // cen pulses seen by the DUT since reset release
    always @(posedge clk) begin
        if (rst_n && mcu_rstb && cen) begin
            cen_seen = cen_seen + 1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Next drive point
    task automatic step();
        @(posedge clk);
        #DRV;
    endtask

    // Sub write, strobe held low for hold edges
    task automatic sub_write(input logic [15:0] addr, input sub_bus_pkg::byte_t data,
                             input int hold);
        step();
        sub_addr   = addr;
        sub_dout   = data;
        sub_mreq_n = 1'b0;
        sub_wr_n   = 1'b0;
        repeat (hold) step();
        sub_mreq_n = 1'b1;
        sub_wr_n   = 1'b1;
    endtask

    task automatic sub_read(input logic [15:0] addr, output sub_bus_pkg::byte_t data);
        step();
        sub_addr   = addr;
        sub_mreq_n = 1'b0;
        sub_wr_n   = 1'b1;
        step();
        data       = sub_din;
        sub_mreq_n = 1'b1;
    endtask

    task automatic main_write(input int idx, input sub_bus_pkg::byte_t data);
        step();
        main_addr = main_addr_t'(idx);
        main_dout = data;
        main_cs   = 1'b1;
        main_wr_n = 1'b0;
        step();
        main_cs   = 1'b0;
        main_wr_n = 1'b1;
    endtask

    task automatic main_read(input int idx, output sub_bus_pkg::byte_t data);
        step();
        main_addr = main_addr_t'(idx);
        step();
        data = shared_dout;
    endtask

    task automatic test_reset();
        int guard;
        repeat (2) step();
        // Control outputs idle while in reset
        check_eq("sub_rst_n", 32'(sub_rst_n), 32'd0);
        check_eq("rom_cs", 32'(rom_cs), 32'd0);
        check_eq("sub_wait_n", 32'(sub_wait_n), 32'd1);
        check_eq("sub_nmi_n", 32'(sub_nmi_n), 32'd1);
        check_eq("sub_busak_n", 32'(sub_busak_n), 32'd1);
        check_eq("main_halt_ack", 32'(main_halt_ack), 32'd0);
        check_eq("main_irq", 32'(main_irq), 32'd0);
        repeat (2) step();
        rst_n = 1'b1;
        guard = 0;
        while (sub_rst_n !== 1'b1 && guard < TIMEOUT) begin
            step();
            guard++;
        end
        if (sub_rst_n !== 1'b1) begin
            abort_run("Timeout waiting for the sub CPU reset to be released");
        end
        // Must rise on the edge of the last counted tick
        check_eq("cen pulses at sub_rst_n rise", 32'(cen_seen), 32'(RST_TICKS));
    endtask

    task automatic test_rom_fetch();
        int                 delay;
        int                 waited;
        logic [15:0]        addr;
        sub_bus_pkg::byte_t data;
        repeat (4) begin
            addr  = 16'($urandom % 32'hc000);
            data  = 8'($urandom);
            delay = 1 + int'($urandom % 6);
            step();
            sub_addr   = addr;
            sub_mreq_n = 1'b0;
            sub_wr_n   = 1'b1;
            rom_data   = data;
            rom_ok     = 1'b0;
            #SETTLE;
            check_eq("rom_addr", 32'(rom_addr), 32'(addr));
            check_eq("rom_cs", 32'(rom_cs), 32'd1);
            check_eq("sub_wait_n", 32'(sub_wait_n), 32'd0);
            waited = 0;
            // ROM answers after a random delay
            while (sub_wait_n !== 1'b1 && waited < TIMEOUT) begin
                step();
                waited++;
                if (waited == delay) begin
                    rom_ok = 1'b1;
                end
                #SETTLE;
            end
            if (sub_wait_n !== 1'b1) begin
                abort_run("Timeout waiting for sub_wait_n to rise during a ROM fetch");
            end
            check_eq("cycles with sub_wait_n low", 32'(waited), 32'(delay));
            check_eq("sub_din", 32'(sub_din), 32'(data));
            step();
            sub_mreq_n = 1'b1;
            rom_ok     = 1'b0;
        end
        // Unmapped read
        step();
        sub_addr   = 16'hf000;
        sub_mreq_n = 1'b0;
        #SETTLE;
        check_eq("rom_cs", 32'(rom_cs), 32'd0);
        check_eq("sub_wait_n", 32'(sub_wait_n), 32'd1);
        check_eq("sub_din", 32'(sub_din), 32'hff);
        step();
        sub_mreq_n = 1'b1;
    endtask

    task automatic test_shared_ram();
        sub_bus_pkg::byte_t got;
        for (int i = 0; i < SPAN; i++) begin
            model.push_back(8'($urandom));
            sub_write(16'hc000 + 16'(i), model[i], 1);
        end
        for (int i = 0; i < SPAN; i++) begin
            sub_read(16'hc000 + 16'(i), got);
            check_eq("sub_din", 32'(got), 32'(model[i]));
        end
        for (int i = 0; i < SPAN; i++) begin
            main_read(i, got);
            check_eq("shared_dout", 32'(got), 32'(model[i]));
        end
    endtask

    task automatic test_halt();
        int                 guard;
        int                 k;
        int                 j;
        sub_bus_pkg::byte_t got;
        k = int'($urandom % SPAN);
        j = (k + 1) % SPAN;
        step();
        main_halt_req = 1'b1;
        guard = 0;
        while (main_halt_ack !== 1'b1 && guard < TIMEOUT) begin
            step();
            guard++;
        end
        if (main_halt_ack !== 1'b1) begin
            abort_run("Timeout waiting for main_halt_ack to rise");
        end
        // Idle sub bus, so granted on the first edge
        check_eq("cycles to main_halt_ack", 32'(guard), 32'd1);
        check_eq("sub_busak_n", 32'(sub_busak_n), 32'd0);
        model[k] = model[k] ^ 8'ha5;
        main_write(k, model[k]);
        step();
        main_halt_req = 1'b0;
        guard = 0;
        while (main_halt_ack !== 1'b0 && guard < TIMEOUT) begin
            step();
            guard++;
        end
        if (main_halt_ack !== 1'b0) begin
            abort_run("Timeout waiting for main_halt_ack to fall");
        end
        check_eq("cycles to main_halt_ack release", 32'(guard), 32'd1);
        check_eq("sub_busak_n", 32'(sub_busak_n), 32'd1);
        // Without the grant this write is dropped
        main_write(j, model[j] ^ 8'h5a);
        sub_read(16'hc000 + 16'(k), got);
        check_eq("sub_din after granted write", 32'(got), 32'(model[k]));
        sub_read(16'hc000 + 16'(j), got);
        check_eq("sub_din after dropped write", 32'(got), 32'(model[j]));
        main_read(j, got);
        check_eq("shared_dout after dropped write", 32'(got), 32'(model[j]));
    endtask

    task automatic test_nmi_irq();
        logic [3:0] seen;
        step();
        main_nmi_set = 1'b1;
        step();
        check_eq("sub_nmi_n", 32'(sub_nmi_n), 32'd0);
        main_nmi_set = 1'b0;
        // Latch holds after the request drops
        repeat (3) step();
        check_eq("sub_nmi_n before acknowledge", 32'(sub_nmi_n), 32'd0);
        sub_write(16'hd000, 8'h00, 1);
        check_eq("sub_nmi_n after acknowledge", 32'(sub_nmi_n), 32'd1);
        // Long write strobe still gives one pulse
        seen = 4'd0;
        step();
        sub_addr   = 16'he000;
        sub_dout   = 8'($urandom);
        sub_mreq_n = 1'b0;
        sub_wr_n   = 1'b0;
        repeat (4) begin
            step();
            seen = {main_irq, seen[3:1]};
        end
        sub_mreq_n = 1'b1;
        sub_wr_n   = 1'b1;
        check_eq("main_irq per cycle", 32'(seen), 32'h1);
    endtask

    initial begin
        void'($urandom(32'h1fb9_bbcd));
        rst_n         = 1'b0;
        mcu_rstb      = 1'b1;
        sub_addr      = 16'h0000;
        sub_mreq_n    = 1'b1;
        sub_rfsh_n    = 1'b1;
        sub_wr_n      = 1'b1;
        sub_dout      = 8'h00;
        rom_data      = 8'h00;
        rom_ok        = 1'b0;
        main_addr     = '0;
        main_dout     = 8'h00;
        main_wr_n     = 1'b1;
        main_cs       = 1'b0;
        main_halt_req = 1'b0;
        main_nmi_set  = 1'b0;
        test_reset();
        test_rom_fetch();
        test_shared_ram();
        test_halt();
        test_nmi_irq();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* sources.f */
src/sub_map_pkg.sv
src/sub_bus_pkg.sv
src/sub_ctrl.sv
src/sub_addr_decode.sv
src/shared_ram.sv
src/main_bus_arbiter.sv
src/sub_bridge_top.sv
verification/tb_sub_bridge.sv

/* Makefile */
# Verilator build and run for the sub bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_sub_bridge
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass message
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
